// ==== src/cmp_count_pkg.sv ====
package cmp_count_pkg;

  // ========================================================================
  // Geometry of a beat and of the counters
  // ========================================================================

  localparam int lanes   = 16;  // 32-bit words per 512-bit beat
  localparam int lane_w  = 32;  // Lane and threshold width
  localparam int count_w = 5;   // Per-beat hit count, 0 to lanes
  localparam int total_w = 32;  // Running match total

  // ========================================================================
  // Comparison operator
  // ========================================================================

  // Codes 6 and 7 are left unnamed and select no lane at all
  typedef enum logic [2:0] {
    op_eq = 3'd0,  // lane == threshold
    op_ne = 3'd1,  // lane != threshold
    op_lt = 3'd2,  // lane <  threshold
    op_le = 3'd3,  // lane <= threshold
    op_gt = 3'd4,  // lane >  threshold
    op_ge = 3'd5   // lane >= threshold
  } cmp_op_e;

  // ========================================================================
  // Stage payloads, each with its own valid and last
  // ========================================================================

  // Input beat, 2 + 16 * 32 = 514 bits
  typedef struct packed {
    logic                               valid;
    logic                               last;
    logic [lanes-1:0][lane_w-1:0]       data;   // Lane 0 in the low word
  } beat_t;

  // Raw compare result, one less and one equal bit per lane
  typedef struct packed {
    logic                               valid;
    logic                               last;
    logic [lanes-1:0]                   less;
    logic [lanes-1:0]                   equal;
  } flags_t;

  // Per-lane hit after the operator has been applied
  typedef struct packed {
    logic                               valid;
    logic                               last;
    logic [lanes-1:0]                   hit;
  } hits_t;

  // Number of hits in one beat
  typedef struct packed {
    logic                               valid;
    logic                               last;
    logic [count_w-1:0]                 count;
  } count_t;

endpackage

// ==== src/lane_compare.sv ====
`timescale 1ns/100ps

module lane_compare (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  cmp_count_pkg::cmp_op_e                    test_type,
  input  logic [cmp_count_pkg::lane_w-1:0]          test_condition,
  input  cmp_count_pkg::beat_t                      in_beat,
  output cmp_count_pkg::hits_t                      hits
);

  logic [cmp_count_pkg::lanes-1:0]  less_d;
  logic [cmp_count_pkg::lanes-1:0]  equal_d;
  logic [cmp_count_pkg::lanes-1:0]  hit_d;

  cmp_count_pkg::flags_t            flags_q;
  cmp_count_pkg::cmp_op_e           op_q;     // Operator travelling with stage 1

  // ========================================================================
  // Stage 1: unsigned less and equal per lane
  // ========================================================================

  always_comb begin
    for (int i = 0; i < cmp_count_pkg::lanes; i++) begin
      // Bubbles produce all-zero flags
      less_d[i]  = in_beat.valid && (in_beat.data[i] < test_condition);
      equal_d[i] = in_beat.valid && (in_beat.data[i] == test_condition);
    end
  end

  always_ff @(posedge clk) begin
    flags_q.less  <= less_d;
    flags_q.equal <= equal_d;
    op_q          <= test_type;
    if (!rst_n) begin
      flags_q.valid <= 1'b0;
      flags_q.last  <= 1'b0;
    end else begin
      flags_q.valid <= in_beat.valid;
      flags_q.last  <= in_beat.valid & in_beat.last;
    end
  end

  // ========================================================================
  // Stage 2: pick the hit per lane from the registered operator
  // ========================================================================

  always_comb begin
    case (op_q)
      cmp_count_pkg::op_eq: hit_d = flags_q.equal;
      cmp_count_pkg::op_ne: hit_d = ~flags_q.equal;
      cmp_count_pkg::op_lt: hit_d = flags_q.less;
      cmp_count_pkg::op_le: hit_d = flags_q.less | flags_q.equal;
      cmp_count_pkg::op_gt: hit_d = ~(flags_q.less | flags_q.equal);
      cmp_count_pkg::op_ge: hit_d = ~flags_q.less;
      default:              hit_d = '0;   // Codes 6 and 7 match nothing
    endcase
    // Keep bubbles clean for the inverted operators
    if (!flags_q.valid) begin
      hit_d = '0;
    end
  end

  always_ff @(posedge clk) begin
    hits.hit <= hit_d;
    if (!rst_n) begin
      hits.valid <= 1'b0;
      hits.last  <= 1'b0;
    end else begin
      hits.valid <= flags_q.valid;
      hits.last  <= flags_q.last;
    end
  end

  // ========================================================================
  // Checks
  // ========================================================================

  // The operator is sampled with the beat and decoded one cycle later,
  // so an X here would silently turn into a zero count downstream
  a_op_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_beat.valid |-> !$isunknown(test_type)
  );

  // Operator must hold while a beat is between the two stages
  a_op_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    flags_q.valid |-> (test_type == op_q)
  );

endmodule

// ==== src/ones_counter.sv ====
`timescale 1ns/100ps

module ones_counter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cmp_count_pkg::hits_t    hits,
  output cmp_count_pkg::count_t   count
);

  logic [3:0][2:0]  nib_q;    // Hits per group of 4 lanes, 0 to 4
  logic [1:0][3:0]  byte_q;   // Hits per group of 8 lanes, 0 to 8
  logic [1:0]       valid_q;
  logic [1:0]       last_q;

  // ========================================================================
  // Level 1: pairs into nibbles
  // ========================================================================

  always_ff @(posedge clk) begin
    for (int n = 0; n < 4; n++) begin
      nib_q[n] <= {1'b0, 2'(hits.hit[4*n]) + 2'(hits.hit[4*n+1])}
                + {1'b0, 2'(hits.hit[4*n+2]) + 2'(hits.hit[4*n+3])};
    end
  end

  // ========================================================================
  // Level 2: nibbles into bytes
  // ========================================================================

  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      byte_q[b] <= {1'b0, nib_q[2*b]} + {1'b0, nib_q[2*b+1]};
    end
  end

  // ========================================================================
  // Level 3: final sum
  // ========================================================================

  always_ff @(posedge clk) begin
    count.count <= {1'b0, byte_q[0]} + {1'b0, byte_q[1]};
  end

  // Valid and last ride beside the adder tree
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= '0;
      last_q      <= '0;
      count.valid <= 1'b0;
      count.last  <= 1'b0;
    end else begin
      valid_q     <= {valid_q[0], hits.valid};
      last_q      <= {last_q[0], hits.last};
      count.valid <= valid_q[1];
      count.last  <= last_q[1];
    end
  end

  // ========================================================================
  // Checks
  // ========================================================================

  a_count_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    count.valid |-> (count.count <= cmp_count_pkg::count_w'(cmp_count_pkg::lanes))
  );

  // Every hit vector comes out as a count three cycles later
  a_count_latency : assert property (
    @(posedge clk) disable iff (!rst_n)
    hits.valid |-> ##3 (count.valid && count.count == $past($countones(hits.hit), 3))
  );

endmodule

// ==== src/match_accum.sv ====
`timescale 1ns/100ps

module match_accum (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  clr,
  input  cmp_count_pkg::count_t                 count,
  output logic [cmp_count_pkg::total_w-1:0]     result_count,
  output logic                                  done
);

  logic [cmp_count_pkg::total_w-1:0]  count_ext;

  // ========================================================================
  // Running total
  // ========================================================================

  assign count_ext = {{(cmp_count_pkg::total_w - cmp_count_pkg::count_w){1'b0}},
                      count.count};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_count <= '0;
    end else if (clr) begin
      result_count <= '0;   // New query drops a count arriving now
    end else if (count.valid) begin
      result_count <= result_count + count_ext;
    end
  end

  // ========================================================================
  // Sticky done
  // ========================================================================

  // Set in the same edge that adds the last count, so the total is
  // already final when done is seen high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (clr) begin
      done <= 1'b0;
    end else if (count.valid && count.last) begin
      done <= 1'b1;
    end
  end

  // ========================================================================
  // Checks
  // ========================================================================

  // Once the last beat has been counted, nothing more may arrive until
  // the next clr; such a beat was sent after last at the input
  a_no_beat_after_last : assert property (
    @(posedge clk) disable iff (!rst_n)
    count.valid |-> !done
  );

endmodule

// ==== src/cmp_count_top.sv ====
`timescale 1ns/100ps

module cmp_count_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  clr,
  input  cmp_count_pkg::cmp_op_e                test_type,
  input  logic [cmp_count_pkg::lane_w-1:0]      test_condition,
  input  cmp_count_pkg::beat_t                  in_beat,
  output logic [cmp_count_pkg::total_w-1:0]     result_count,
  output logic                                  done
);

  // ========================================================================
  // Stage links
  // ========================================================================

  cmp_count_pkg::hits_t   hits;     // 2 cycles after in_beat
  cmp_count_pkg::count_t  count;    // 3 more cycles

  // Compare every lane and apply the operator
  lane_compare u_lane_compare (
    .clk            (clk),
    .rst_n          (rst_n),
    .test_type      (test_type),
    .test_condition (test_condition),
    .in_beat        (in_beat),
    .hits           (hits)
  );

  // Popcount of the 16 hit bits
  ones_counter u_ones_counter (
    .clk            (clk),
    .rst_n          (rst_n),
    .hits           (hits),
    .count          (count)
  );

  // Total and done, one more cycle
  match_accum u_match_accum (
    .clk            (clk),
    .rst_n          (rst_n),
    .clr            (clr),
    .count          (count),
    .result_count   (result_count),
    .done           (done)
  );

endmodule

// ==== dv/tb_cmp_count.sv ====
`timescale 1ns/100ps

module tb_cmp_count;

  // ========================================================================
  // Run setup
  // ========================================================================

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int n_streams    = 12;  // Six operators, two invalid codes, four boundary runs
  localparam int stream_beats = 6;
  localparam int max_gap      = 3;   // Up to 3 bubbles before a beat
  localparam int stream_slack = 24;  // clr, pipeline drain and checks
  localparam int done_latency = 6;   // Edges from driving last to done high
  localparam int watchdog_ns  =
    (n_streams * (stream_beats * (1 + max_gap) + stream_slack) + reset_cycles + 50)
    * clk_period;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       clr;
  cmp_count_pkg::cmp_op_e                     test_type;
  logic [cmp_count_pkg::lane_w-1:0]           test_condition;
  cmp_count_pkg::beat_t                       in_beat;
  logic [cmp_count_pkg::total_w-1:0]          result_count;
  logic                                       done;

  logic [31:0]                                lfsr = 32'd30;
  logic [cmp_count_pkg::total_w-1:0]          exp_total;
  int                                         streams_sent    = 0;
  int                                         streams_checked = 0;

  cmp_count_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .clr            (clr),
    .test_type      (test_type),
    .test_condition (test_condition),
    .in_beat        (in_beat),
    .result_count   (result_count),
    .done           (done)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ========================================================================
  // Random source and reference model
  // ========================================================================

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
    return r;
  endfunction

  // Lane near the threshold most of the time, so equal, less and greater all show up
  function automatic logic [31:0] make_lane(input logic [31:0] thr);
    logic [1:0]  mode;
    logic [2:0]  offs;
    logic [31:0] lane;
    mode = 2'(take_bits(2));
    case (mode)
      2'd0: lane = take_bits(32);                          // Anywhere
      2'd1: lane = take_bits(1) ? 32'hFFFF_FFFF : 32'h0;   // Extremes
      default: begin
        offs = 3'(take_bits(3));
        lane = thr + {{29{offs[2]}}, offs};                // Offset -4 to +3 with wraparound
      end
    endcase
    return lane;
  endfunction

  // Expected hits in one beat, unsigned compare of every lane
  function automatic int count_hits(
    input logic [cmp_count_pkg::lanes-1:0][cmp_count_pkg::lane_w-1:0] data,
    input logic [cmp_count_pkg::lane_w-1:0]                           thr,
    input logic [2:0]                                                 op
  );
    int   n;
    logic hit;
    n = 0;
    for (int l = 0; l < cmp_count_pkg::lanes; l++) begin
      case (op)
        3'd0:    hit = (data[l] == thr);
        3'd1:    hit = (data[l] != thr);
        3'd2:    hit = (data[l] <  thr);
        3'd3:    hit = (data[l] <= thr);
        3'd4:    hit = (data[l] >  thr);
        3'd5:    hit = (data[l] >= thr);
        default: hit = 1'b0;
      endcase
      if (hit) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // ========================================================================
  // Stimulus
  // ========================================================================

  task automatic run_stream(input logic [2:0] op, input logic [31:0] thr);
    cmp_count_pkg::beat_t beat;
    cmp_count_pkg::beat_t idle;
    int                   gap;
    idle.valid = 1'b0;
    idle.last  = 1'b0;
    for (int l = 0; l < cmp_count_pkg::lanes; l++) begin
      idle.data[l] = thr;   // Would hit op_eq if a bubble were counted
    end

    // New query while nothing is in flight
    @(posedge clk);
    test_type      <= cmp_count_pkg::cmp_op_e'(op);
    test_condition <= thr;
    clr            <= 1'b1;
    @(posedge clk);
    clr            <= 1'b0;
    @(negedge clk);
    check_value("result_count", result_count, '0);
    check_value("done", {31'b0, done}, 32'h0);

    exp_total = '0;
    for (int b = 0; b < stream_beats; b++) begin
      gap = int'(take_bits(2));
      repeat (gap) begin
        @(posedge clk);
        in_beat <= idle;
      end
      beat.valid = 1'b1;
      beat.last  = (b == stream_beats - 1);
      for (int l = 0; l < cmp_count_pkg::lanes; l++) begin
        beat.data[l] = make_lane(thr);
      end
      exp_total = exp_total + 32'(count_hits(beat.data, thr, op));
      @(posedge clk);
      in_beat <= beat;
      if (beat.last) begin
        streams_sent <= streams_sent + 1;
      end
    end
    @(posedge clk);
    in_beat <= idle;

    wait (streams_checked == streams_sent);
  endtask

  initial begin : stimulus
    logic [2:0]  op;
    logic [31:0] thr;
    rst_n          <= 1'b0;
    clr            <= 1'b0;
    test_type      <= cmp_count_pkg::op_eq;
    test_condition <= '0;
    in_beat        <= '0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("result_count", result_count, '0);   // Clean state out of reset
    check_value("done", {31'b0, done}, 32'h0);

    for (int s = 0; s < n_streams; s++) begin
      if (s < 8) begin
        op  = 3'(s);          // All six operators, then codes 6 and 7
        thr = take_bits(32);
      end else begin
        case (s)
          8: begin
            op  = 3'd3;
            thr = 32'h0000_0000;
          end
          9: begin
            op  = 3'd4;
            thr = 32'h0000_0000;
          end
          10: begin
            op  = 3'd2;
            thr = 32'hFFFF_FFFF;
          end
          default: begin
            op  = 3'd5;
            thr = 32'hFFFF_FFFF;
          end
        endcase
      end
      run_stream(op, thr);
    end

    @(negedge clk);
    $display("Everything OK");
    $finish;
  end

  // ========================================================================
  // Compare
  // ========================================================================

  // Starts at the negedge right after the last beat is driven
  initial begin : compare
    forever begin
      @(negedge clk);
      if (streams_sent > streams_checked) begin
        // done stays low while the last beat is in the pipeline
        for (int e = 1; e < done_latency; e++) begin
          @(negedge clk);
          check_value("done", {31'b0, done}, 32'h0);
        end
        @(negedge clk);
        check_value("done", {31'b0, done}, 32'h1);
        check_value("result_count", result_count, exp_total);
        streams_checked = streams_checked + 1;
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("Timeout: the streams did not finish within %0d ns", watchdog_ns);
    $display("Something failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== verilog.f ====
src/cmp_count_pkg.sv
src/lane_compare.sv
src/ones_counter.sv
src/match_accum.sv
src/cmp_count_top.sv
dv/tb_cmp_count.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the compare-count testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  -f verilog.f --top-module tb_cmp_count -o tb_cmp_count \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_cmp_count > sim.log 2>&1
cat sim.log

[ -s sim.log ] || { echo "No simulation output"; exit 1; }

grep -q "Something failed" sim.log \
  && { echo "Simulation reported a failure, see sim.log"; exit 1; } \
  || echo "Simulation passed"

exit 0
